// File: dtlb.f
+incdir+rtl
rtl/dtlb_pkg.sv
rtl/dtlb_if.sv
rtl/tlb_lookup.sv
rtl/plru_tree.sv
rtl/dtlb_miss_arbiter.sv
rtl/dtlb_fence_ctrl.sv
rtl/dtlb_top.sv
verif/dtlb_assertions.sv
verif/tb_dtlb.sv

// File: rtl/dtlb_cfg.svh
`ifndef DTLB_CFG_SVH
`define DTLB_CFG_SVH

`define DTLB_ENTRIES 8
`define DTLB_IDX_W   3

`define VADDR_W      32
`define PADDR_W      32
`define PAGE_OFS_W   12
`define VPN_W        20      // two levels of 10 bits.
`define VPN_LVL_W    10
`define PPN_W        20
`define ASID_W       9

`endif

// File: rtl/dtlb_fence_ctrl.sv
`include "dtlb_cfg.svh"

module dtlb_fence_ctrl import dtlb_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  logic                l2_valid_i,
    input  logic                l2_error_i,
    input  logic [`VADDR_W-1:0] l2_vaddr_i,
    input  tlb_entry_t          l2_entry_i,
    input  logic [`ASID_W-1:0]  asid_i,
    input  logic                fence_i,
    input  logic                fence_all_i,
    input  logic [`VADDR_W-1:0] fence_vaddr_i,
    input  logic [`ASID_W-1:0]  fence_asid_i,
    input  logic                fence_asid_all_i,
    output logic                fence_busy_o,
    tlb_refill_if.writer        rf
);

    logic [`DTLB_ENTRIES-1:0] dir_valid;
    logic [`VPN_W-1:0]        dir_vpn  [`DTLB_ENTRIES];
    logic [`ASID_W-1:0]       dir_asid [`DTLB_ENTRIES];
    logic [`DTLB_ENTRIES-1:0] dir_glob;

    fence_state_e             state;
    logic                     end_q;
    logic                     fence_we;
    logic [`DTLB_IDX_W-1:0]   fence_idx;
    logic [`VPN_W-1:0]        fence_vpn;
    logic [`ASID_W-1:0]       fence_asid;
    logic                     fence_asid_all;

    logic [`VPN_W-1:0]        refill_vpn, cmp_vpn;
    logic [`ASID_W-1:0]       cmp_asid;
    logic [`DTLB_ENTRIES-1:0] cmp_hit;
    logic [`DTLB_IDX_W-1:0]   hit_idx, free_idx, victim_idx, refill_idx;
    logic                     any_free;
    logic                     refill_we;

    assign refill_we  = l2_valid_i & ~l2_error_i & ~flush_i;
    assign refill_vpn = l2_vaddr_i[`VADDR_W-1:`PAGE_OFS_W];
    assign cmp_vpn    = (state == FENCE_MATCH) ? fence_vpn : refill_vpn;
    assign cmp_asid   = (state == FENCE_MATCH) ? fence_asid : asid_i;

    always_comb begin
        hit_idx  = '0;
        free_idx = '0;
        any_free = 1'b0;
        for (int i = `DTLB_ENTRIES-1; i >= 0; i--) begin   // lowest wins.
            cmp_hit[i] = dir_valid[i] && dir_vpn[i] == cmp_vpn &&
                         (dir_asid[i] == cmp_asid || dir_glob[i] ||
                          (state == FENCE_MATCH && fence_asid_all));
            if (cmp_hit[i]) begin
                hit_idx = `DTLB_IDX_W'(i);
            end
            if (!dir_valid[i]) begin
                free_idx = `DTLB_IDX_W'(i);
                any_free = 1'b1;
            end
        end
    end

    assign refill_idx = |cmp_hit ? hit_idx : (any_free ? free_idx : victim_idx);

    plru_tree u_plru (
        .clk         (clk),
        .rst         (rst),
        .touch_i     (refill_we & ~fence_we),
        .touch_idx_i (refill_idx),
        .victim_o    (victim_idx)
    );

    // fence writes win.
    assign rf.we    = fence_we | refill_we;
    assign rf.inval = fence_we;
    assign rf.widx  = fence_we ? fence_idx : refill_idx;
    assign rf.vpn   = refill_vpn;
    assign rf.asid  = asid_i;
    assign rf.entry = l2_entry_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dir_valid <= '0;
        end else if (rf.we) begin
            dir_valid[rf.widx] <= ~fence_we;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we && !fence_we) begin
            dir_vpn[refill_idx]  <= refill_vpn;
            dir_asid[refill_idx] <= asid_i;
            dir_glob[refill_idx] <= l2_entry_i.glob;
        end
        if (state == FENCE_IDLE && fence_i) begin
            fence_vpn      <= fence_vaddr_i[`VADDR_W-1:`PAGE_OFS_W];
            fence_asid     <= fence_asid_i;
            fence_asid_all <= fence_asid_all_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // sfence.vma state machine.
    ////////////////////////////////////////////////////////////////////////
    assign fence_busy_o = (state != FENCE_IDLE) | end_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= FENCE_IDLE;
            end_q     <= 1'b0;
            fence_we  <= 1'b0;
            fence_idx <= '0;
        end else begin
            end_q <= (state == FENCE_END);
            case (state)
                FENCE_IDLE: begin
                    if (fence_i && !fence_busy_o) begin
                        fence_idx <= '0;
                        fence_we  <= fence_all_i;
                        state     <= fence_all_i ? FENCE_ALL : FENCE_MATCH;
                    end
                end
                FENCE_MATCH: begin
                    fence_we  <= |cmp_hit;   // written during FENCE_END.
                    fence_idx <= hit_idx;
                    state     <= FENCE_END;
                end
                FENCE_ALL: begin
                    fence_idx <= fence_idx + 1'b1;
                    if (fence_idx == `DTLB_IDX_W'(`DTLB_ENTRIES-2)) begin
                        state <= FENCE_END;   // last slot goes in FENCE_END.
                    end
                end
                default: begin
                    fence_we <= 1'b0;
                    state    <= FENCE_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/dtlb_if.sv
`include "dtlb_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// lookup port.
////////////////////////////////////////////////////////////////////////////
interface tlb_lookup_if;
    logic                req;
    logic [`VADDR_W-1:0] vaddr;
    logic [`ASID_W-1:0]  asid;
    logic                miss;
    logic                fault;
    logic [`PADDR_W-1:0] paddr;

    modport lsu (
        output req, vaddr, asid,
        input  miss, fault, paddr
    );

    modport tlb (
        input  req, vaddr, asid,
        output miss, fault, paddr
    );
endinterface

////////////////////////////////////////////////////////////////////////////
// refill and invalidate, one write per cycle into both arrays.
////////////////////////////////////////////////////////////////////////////
interface tlb_refill_if import dtlb_pkg::*; ();
    logic                   we;
    logic                   inval;     // only widx counts when set.
    logic [`DTLB_IDX_W-1:0] widx;
    logic [`VPN_W-1:0]      vpn;
    logic [`ASID_W-1:0]     asid;
    tlb_entry_t             entry;

    modport writer (output we, inval, widx, vpn, asid, entry);

    modport array (input we, inval, widx, vpn, asid, entry);
endinterface

// File: rtl/dtlb_miss_arbiter.sv
`include "dtlb_cfg.svh"

module dtlb_miss_arbiter import dtlb_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    tlb_lookup_if.lsu           ld,
    tlb_lookup_if.lsu           st,
    input  logic                ld_req_i,
    input  logic [`VADDR_W-1:0] ld_vaddr_i,
    input  logic                st_req_i,
    input  logic [`VADDR_W-1:0] st_vaddr_i,
    input  logic [`ASID_W-1:0]  asid_i,
    output logic                l2_req_o,
    output logic [`VADDR_W-1:0] l2_vaddr_o,
    output logic                l2_src_o,
    input  logic                l2_ready_i,
    input  logic                l2_valid_i,
    input  logic                l2_src_i,
    input  logic                l2_error_i,
    output logic                ld_replay_o,
    output logic                st_replay_o,
    output logic                ld_wb_o,
    output logic                st_wb_o,
    output logic                wb_fault_o
);

    logic [`VADDR_W-1:0] ld_vaddr_q, st_vaddr_q;
    logic                walk_out;    // transferred, answer not back yet.
    logic                walk_drop;   // flushed while out.
    logic                busy;
    logic                st_go, ld_go;
    logic                drop_wb;

    assign ld.req   = ld_req_i;
    assign ld.vaddr = ld_vaddr_i;
    assign ld.asid  = asid_i;
    assign st.req   = st_req_i;
    assign st.vaddr = st_vaddr_i;
    assign st.asid  = asid_i;

    assign busy    = l2_req_o | walk_out;
    assign st_go   = st.miss & ~busy & ~flush_i;   // store first.
    assign ld_go   = ld.miss & ~st.miss & ~busy & ~flush_i;
    assign drop_wb = flush_i | walk_drop;

    always_ff @(posedge clk) begin
        ld_vaddr_q <= ld_vaddr_i;
        st_vaddr_q <= st_vaddr_i;
        if (st_go || ld_go) begin
            l2_vaddr_o <= st_go ? st_vaddr_q : ld_vaddr_q;
            l2_src_o   <= st_go ? SRC_STORE : SRC_LOAD;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            l2_req_o    <= 1'b0;
            walk_out    <= 1'b0;
            walk_drop   <= 1'b0;
            ld_replay_o <= 1'b0;
            st_replay_o <= 1'b0;
            ld_wb_o     <= 1'b0;
            st_wb_o     <= 1'b0;
            wb_fault_o  <= 1'b0;
        end else begin
            if (l2_req_o) begin
                l2_req_o <= ~l2_ready_i & ~flush_i;   // hold until ready.
            end else begin
                l2_req_o <= st_go | ld_go;
            end
            if (l2_req_o && l2_ready_i) begin
                walk_out <= 1'b1;
            end else if (l2_valid_i) begin
                walk_out <= 1'b0;
            end
            if (l2_valid_i) begin
                walk_drop <= 1'b0;
            end else if (flush_i && (walk_out || (l2_req_o && l2_ready_i))) begin
                walk_drop <= 1'b1;
            end
            ld_replay_o <= ld.miss & (busy | st.miss);
            st_replay_o <= st.miss & busy;
            ld_wb_o     <= l2_valid_i & ~drop_wb & (l2_src_i == SRC_LOAD);
            st_wb_o     <= l2_valid_i & ~drop_wb & (l2_src_i == SRC_STORE);
            wb_fault_o  <= l2_valid_i & l2_error_i;
        end
    end

endmodule

// File: rtl/dtlb_pkg.sv
`include "dtlb_cfg.svh"

package dtlb_pkg;

    // one stored translation, 24 bits.
    typedef struct packed {
        logic [`PPN_W-1:0] ppn;
        logic              readable;
        logic              writable;
        logic              glob;
        logic              superpage;
    } tlb_entry_t;

    // port a walk belongs to.
    typedef enum logic [0:0] {
        SRC_LOAD  = 1'b0,
        SRC_STORE = 1'b1
    } miss_src_e;

    typedef enum logic [1:0] {
        FENCE_IDLE  = 2'd0,
        FENCE_MATCH = 2'd1,
        FENCE_ALL   = 2'd2,
        FENCE_END   = 2'd3
    } fence_state_e;

endpackage

// File: rtl/dtlb_top.sv
`include "dtlb_cfg.svh"

module dtlb_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  logic [`ASID_W-1:0]  asid_i,
    input  logic                ld_req_i,
    input  logic [`VADDR_W-1:0] ld_vaddr_i,
    output logic                ld_miss_o,
    output logic                ld_fault_o,
    output logic [`PADDR_W-1:0] ld_paddr_o,
    input  logic                st_req_i,
    input  logic [`VADDR_W-1:0] st_vaddr_i,
    output logic                st_miss_o,
    output logic                st_fault_o,
    output logic [`PADDR_W-1:0] st_paddr_o,
    output logic                l2_req_o,
    output logic [`VADDR_W-1:0] l2_vaddr_o,
    output logic                l2_src_o,
    input  logic                l2_ready_i,
    input  logic                l2_valid_i,
    input  logic                l2_src_i,
    input  logic                l2_error_i,
    input  logic [`VADDR_W-1:0] l2_vaddr_i,
    input  logic [`PPN_W-1:0]   l2_ppn_i,
    input  logic                l2_readable_i,
    input  logic                l2_writable_i,
    input  logic                l2_global_i,
    input  logic                l2_superpage_i,
    output logic                ld_replay_o,
    output logic                st_replay_o,
    output logic                ld_wb_o,
    output logic                st_wb_o,
    output logic                wb_fault_o,
    input  logic                fence_i,
    input  logic                fence_all_i,
    input  logic [`VADDR_W-1:0] fence_vaddr_i,
    input  logic [`ASID_W-1:0]  fence_asid_i,
    input  logic                fence_asid_all_i,
    output logic                fence_busy_o
);

    tlb_lookup_if ld_if ();
    tlb_lookup_if st_if ();
    tlb_refill_if rf_if ();

    assign ld_miss_o  = ld_if.miss;
    assign ld_fault_o = ld_if.fault;
    assign ld_paddr_o = ld_if.paddr;
    assign st_miss_o  = st_if.miss;
    assign st_fault_o = st_if.fault;
    assign st_paddr_o = st_if.paddr;

    dtlb_miss_arbiter u_arb (
        .clk(clk), .rst(rst), .flush_i(flush_i), .ld(ld_if), .st(st_if),
        .ld_req_i(ld_req_i), .ld_vaddr_i(ld_vaddr_i),
        .st_req_i(st_req_i), .st_vaddr_i(st_vaddr_i), .asid_i(asid_i),
        .l2_req_o(l2_req_o), .l2_vaddr_o(l2_vaddr_o), .l2_src_o(l2_src_o),
        .l2_ready_i(l2_ready_i), .l2_valid_i(l2_valid_i), .l2_src_i(l2_src_i),
        .l2_error_i(l2_error_i), .ld_replay_o(ld_replay_o), .st_replay_o(st_replay_o),
        .ld_wb_o(ld_wb_o), .st_wb_o(st_wb_o), .wb_fault_o(wb_fault_o)
    );

    // entry fields in struct order: ppn, r, w, g, superpage.
    dtlb_fence_ctrl u_fence (
        .clk(clk), .rst(rst), .flush_i(flush_i),
        .l2_valid_i(l2_valid_i), .l2_error_i(l2_error_i), .l2_vaddr_i(l2_vaddr_i),
        .l2_entry_i({l2_ppn_i, l2_readable_i, l2_writable_i, l2_global_i,
                     l2_superpage_i}),
        .asid_i(asid_i), .fence_i(fence_i), .fence_all_i(fence_all_i),
        .fence_vaddr_i(fence_vaddr_i), .fence_asid_i(fence_asid_i),
        .fence_asid_all_i(fence_asid_all_i), .fence_busy_o(fence_busy_o),
        .rf(rf_if)
    );

    tlb_lookup u_ld_tlb (.clk(clk), .rst(rst), .lk(ld_if), .rf(rf_if), .is_store_i(1'b0));
    tlb_lookup u_st_tlb (.clk(clk), .rst(rst), .lk(st_if), .rf(rf_if), .is_store_i(1'b1));

endmodule

// File: rtl/plru_tree.sv
`include "dtlb_cfg.svh"

module plru_tree import dtlb_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   touch_i,
    input  logic [`DTLB_IDX_W-1:0] touch_idx_i,
    output logic [`DTLB_IDX_W-1:0] victim_o
);

    // node 0 is the root, node n has children 2n+1 and 2n+2.
    logic [`DTLB_ENTRIES-2:0] tree;
    logic [2:0]               t_node1, t_node2;
    logic [2:0]               v_node1, v_node2;

    assign t_node1 = 3'd1 + {2'b00, touch_idx_i[2]};
    assign t_node2 = 3'd3 + {1'b0, touch_idx_i[2:1]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tree <= '0;
        end else if (touch_i) begin
            tree[0]       <= ~touch_idx_i[2];   // point away.
            tree[t_node1] <= ~touch_idx_i[1];
            tree[t_node2] <= ~touch_idx_i[0];
        end
    end

    assign v_node1     = 3'd1 + {2'b00, tree[0]};
    assign v_node2     = 3'd3 + {1'b0, tree[0], tree[v_node1]};
    assign victim_o    = {tree[0], tree[v_node1], tree[v_node2]};

endmodule

// File: rtl/tlb_lookup.sv
`include "dtlb_cfg.svh"

module tlb_lookup import dtlb_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    tlb_lookup_if.tlb   lk,
    tlb_refill_if.array rf,
    input  logic        is_store_i
);

    logic [`DTLB_ENTRIES-1:0] valid;
    logic [`VPN_W-1:0]        vpn   [`DTLB_ENTRIES];
    logic [`ASID_W-1:0]       asid  [`DTLB_ENTRIES];
    tlb_entry_t               entry [`DTLB_ENTRIES];

    logic                  hit;
    tlb_entry_t            hit_entry;
    logic [`VPN_LVL_W-1:0] req_vpn1;
    logic [`VPN_LVL_W-1:0] req_vpn0;

    assign req_vpn1 = lk.vaddr[`VADDR_W-1 -: `VPN_LVL_W];
    assign req_vpn0 = lk.vaddr[`PAGE_OFS_W +: `VPN_LVL_W];

    always_comb begin
        hit       = 1'b0;
        hit_entry = '0;
        for (int i = 0; i < `DTLB_ENTRIES; i++) begin
            if (valid[i] && (asid[i] == lk.asid || entry[i].glob) &&
                vpn[i][`VPN_W-1 -: `VPN_LVL_W] == req_vpn1 &&
                (entry[i].superpage || vpn[i][`VPN_LVL_W-1:0] == req_vpn0)) begin
                hit       = 1'b1;
                hit_entry = entry[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lk.miss  <= 1'b0;
            lk.fault <= 1'b0;
        end else begin
            lk.miss  <= lk.req & ~hit;
            lk.fault <= lk.req & hit &
                        ~(is_store_i ? hit_entry.writable : hit_entry.readable);
        end
    end

    always_ff @(posedge clk) begin
        if (hit_entry.superpage) begin
            lk.paddr <= {hit_entry.ppn[`PPN_W-1 -: `VPN_LVL_W],
                         lk.vaddr[`PAGE_OFS_W+`VPN_LVL_W-1:0]};  // 4 MiB page.
        end else begin
            lk.paddr <= {hit_entry.ppn, lk.vaddr[`PAGE_OFS_W-1:0]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (rf.we) begin
            valid[rf.widx] <= ~rf.inval;
        end
    end

    always_ff @(posedge clk) begin
        if (rf.we && !rf.inval) begin
            vpn[rf.widx]   <= rf.vpn;
            asid[rf.widx]  <= rf.asid;
            entry[rf.widx] <= rf.entry;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_dtlb -f dtlb.f -o sim_dtlb
./obj_dir/sim_dtlb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "dtlb simulation passed"
else
    echo "dtlb simulation failed"
    exit 1
fi

// File: verif/dtlb_assertions.sv
`include "dtlb_cfg.svh"

module dtlb_assertions (
    input logic                clk,
    input logic                rst,
    input logic                flush_i,
    input logic                l2_req_o,
    input logic                l2_ready_i,
    input logic [`VADDR_W-1:0] l2_vaddr_o,
    input logic                l2_src_o,
    input logic                ld_wb_o,
    input logic                st_wb_o,
    input logic                walk_out
);

    int fail_count = 0;   // failed assertions so far.

    req_stable: assert property (@(posedge clk) disable iff (rst)
        l2_req_o && !l2_ready_i && !flush_i |=>
            l2_req_o && $stable(l2_vaddr_o) && $stable(l2_src_o))
        else begin
            fail_count++;
            $error("walker request changed while not ready");
        end

    // a writeback answers the outstanding walk of its own port.
    wb_onehot: assert property (@(posedge clk) disable iff (rst)
        ld_wb_o || st_wb_o |->
            !(ld_wb_o && st_wb_o) && $past(walk_out) && st_wb_o == $past(l2_src_o))
        else begin
            fail_count++;
            $error("writeback pulse without a matching outstanding walk");
        end

    // one walk at a time.
    no_req_in_walk: assert property (@(posedge clk) disable iff (rst)
        walk_out |=> !$rose(l2_req_o))
        else begin
            fail_count++;
            $error("new walker request while a walk is outstanding");
        end

endmodule

bind dtlb_miss_arbiter dtlb_assertions u_asrt (
    .clk(clk), .rst(rst), .flush_i(flush_i), .l2_req_o(l2_req_o),
    .l2_ready_i(l2_ready_i), .l2_vaddr_o(l2_vaddr_o), .l2_src_o(l2_src_o),
    .ld_wb_o(ld_wb_o), .st_wb_o(st_wb_o), .walk_out(walk_out)
);

// File: verif/tb_dtlb.sv
`include "dtlb_cfg.svh"

module tb_dtlb import dtlb_pkg::*; ();

    localparam int             WALK_LAT   = 3;
    localparam int             WB_LIMIT   = 50;
    localparam int             FENCE_LIMIT = 20;
    localparam logic [`ASID_W-1:0] MAIN_ASID  = 9'h005;
    localparam logic [`ASID_W-1:0] OTHER_ASID = 9'h1a3;

    logic clk, rst, flush_i;
    logic [`ASID_W-1:0]  asid_i;
    logic                ld_req_i, ld_miss_o, ld_fault_o;
    logic [`VADDR_W-1:0] ld_vaddr_i;
    logic [`PADDR_W-1:0] ld_paddr_o;
    logic                st_req_i, st_miss_o, st_fault_o;
    logic [`VADDR_W-1:0] st_vaddr_i;
    logic [`PADDR_W-1:0] st_paddr_o;
    logic                l2_req_o, l2_src_o, l2_ready_i, l2_valid_i, l2_src_i, l2_error_i;
    logic [`VADDR_W-1:0] l2_vaddr_o, l2_vaddr_i;
    logic [`PPN_W-1:0]   l2_ppn_i;
    logic                l2_readable_i, l2_writable_i, l2_global_i, l2_superpage_i;
    logic                ld_replay_o, st_replay_o, ld_wb_o, st_wb_o, wb_fault_o;
    logic                fence_i, fence_all_i, fence_asid_all_i, fence_busy_o;
    logic [`VADDR_W-1:0] fence_vaddr_i;
    logic [`ASID_W-1:0]  fence_asid_i;

    typedef struct packed {
        logic              err;
        logic [`PPN_W-1:0] ppn;
        logic              r;
        logic              w;
        logic              g;
        logic              sp;
    } pte_t;

    pte_t                pt [logic [`VPN_W-1:0]];   // walker page table.
    string               test_name;
    int                  walk_cnt = 0;
    logic [`VADDR_W-1:0] walk_va;
    logic                walk_src;
    pte_t                walk_pte;
    bit                  stall = 1'b0;

    dtlb_top uut (.*);

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // page walker model.
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        l2_valid_i = 1'b0;
        l2_ready_i = !stall;
        if (walk_cnt != 0) begin
            walk_cnt--;
            if (walk_cnt == 0) begin
                walk_pte     = '0;
                walk_pte.err = 1'b1;   // unmapped page.
                if (pt.exists(walk_va[`VADDR_W-1:`PAGE_OFS_W])) begin
                    walk_pte = pt[walk_va[`VADDR_W-1:`PAGE_OFS_W]];
                end
                l2_valid_i     = 1'b1;
                l2_src_i       = walk_src;
                l2_vaddr_i     = walk_va;
                l2_error_i     = walk_pte.err;
                l2_ppn_i       = walk_pte.ppn;
                l2_readable_i  = walk_pte.r;
                l2_writable_i  = walk_pte.w;
                l2_global_i    = walk_pte.g;
                l2_superpage_i = walk_pte.sp;
            end
        end else if (l2_req_o && l2_ready_i) begin   // transfer on next edge.
            walk_va  = l2_vaddr_o;
            walk_src = l2_src_o;
            walk_cnt = WALK_LAT;
        end
    end

    // fresh page with its own level-1 index, so no superpage overlaps it.
    function automatic logic [`VPN_W-1:0] new_page(input logic r, w, g, sp, err);
        logic [`VPN_W-1:0] v;
        bit                clash;
        do begin
            v     = `VPN_W'($urandom);
            clash = 1'b0;
            foreach (pt[k]) begin
                if (k[`VPN_W-1 -: `VPN_LVL_W] == v[`VPN_W-1 -: `VPN_LVL_W]) clash = 1'b1;
            end
        end while (clash);
        pt[v] = '{err: err, ppn: `PPN_W'($urandom), r: r, w: w, g: g, sp: sp};
        return v;
    endfunction

    function automatic logic [`VADDR_W-1:0] va_of(input logic [`VPN_W-1:0] vpn);
        return {vpn, `PAGE_OFS_W'($urandom)};
    endfunction

    function automatic logic [`PADDR_W-1:0] pa_of(input logic [`VPN_W-1:0] key,
                                                   input logic [`VADDR_W-1:0] va);
        pte_t e;
        e = pt[key];
        if (e.sp) return {e.ppn[`PPN_W-1 -: `VPN_LVL_W], va[`PAGE_OFS_W+`VPN_LVL_W-1:0]};
        return {e.ppn, va[`PAGE_OFS_W-1:0]};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            stop_run($sformatf("mismatch %s %s: expected %h, actual %h",
                               test_name, what, exp, act));
        end
    endtask

    // one request cycle, results readable on return.
    task automatic access(input logic ld_en, input logic [`VADDR_W-1:0] ld_va,
                          input logic st_en, input logic [`VADDR_W-1:0] st_va);
        ld_req_i   = ld_en;
        ld_vaddr_i = ld_va;
        st_req_i   = st_en;
        st_vaddr_i = st_va;
        @(negedge clk);
        ld_req_i = 1'b0;
        st_req_i = 1'b0;
    endtask

    task automatic wait_wb(input logic is_st);
        int n;
        n = 0;
        while (!(is_st ? st_wb_o : ld_wb_o)) begin
            if (n == WB_LIMIT) begin
                stop_run($sformatf("%s: no writeback from the walker in time", test_name));
            end else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    task automatic miss_refill(input logic is_st, input logic [`VADDR_W-1:0] va,
                               input logic exp_err);
        access(!is_st, va, is_st, va);
        check("miss", 1, is_st ? st_miss_o : ld_miss_o);
        @(negedge clk);
        check("walk req", 1, l2_req_o);
        check("walk src", is_st ? SRC_STORE : SRC_LOAD, l2_src_o);
        check("walk vaddr", va, l2_vaddr_o);
        wait_wb(is_st);
        check("wb fault", exp_err, wb_fault_o);
    endtask

    task automatic expect_hit(input logic is_st, input logic [`VADDR_W-1:0] va,
                              input logic [`VPN_W-1:0] key);
        access(!is_st, va, is_st, va);
        check("miss", 0, is_st ? st_miss_o : ld_miss_o);
        check("fault", 0, is_st ? st_fault_o : ld_fault_o);
        check("paddr", pa_of(key, va), is_st ? st_paddr_o : ld_paddr_o);
    endtask

    task automatic run_fence(input logic all, input logic [`VADDR_W-1:0] va,
                             input logic [`ASID_W-1:0] asid, input logic asid_all);
        int n;
        fence_i          = 1'b1;
        fence_all_i      = all;
        fence_vaddr_i    = va;
        fence_asid_i     = asid;
        fence_asid_all_i = asid_all;
        @(negedge clk);
        fence_i = 1'b0;
        n = 0;
        while (fence_busy_o) begin
            if (n == FENCE_LIMIT) begin
                stop_run($sformatf("%s: fence never finished", test_name));
            end else begin
                n++;
                @(negedge clk);
            end
        end
        check("busy cycles", all ? `DTLB_ENTRIES + 1 : 3, n);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests.
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_and_refill();
        logic [`VPN_W-1:0]   p;
        logic [`VADDR_W-1:0] va;
        test_name = "reset_and_refill";
        check("idle outputs", 0, {l2_req_o, ld_wb_o, st_wb_o, ld_replay_o, st_replay_o,
                                  fence_busy_o, ld_miss_o, st_miss_o});
        p  = new_page(1, 1, 0, 0, 0);
        va = va_of(p);
        miss_refill(0, va, 0);
        expect_hit(0, va, p);
    endtask

    task automatic permissions_and_faults();
        logic [`VPN_W-1:0]   ro, bad;
        logic [`VADDR_W-1:0] va;
        test_name = "permissions_and_faults";
        ro = new_page(1, 0, 0, 0, 0);
        va = va_of(ro);
        miss_refill(1, va, 0);
        access(0, va, 1, va);
        check("st miss", 0, st_miss_o);
        check("st fault", 1, st_fault_o);
        expect_hit(0, va, ro);
        bad = new_page(1, 1, 0, 0, 1);
        miss_refill(0, va_of(bad), 1);
        miss_refill(0, va_of(bad), 1);   // nothing was written.
    endtask

    task automatic superpage_and_asid();
        logic [`VPN_W-1:0] sp, ng, gl;
        test_name = "superpage_and_asid";
        sp = new_page(1, 1, 0, 1, 0);
        miss_refill(0, va_of(sp), 0);
        expect_hit(0, {sp[`VPN_W-1 -: `VPN_LVL_W], ~sp[`VPN_LVL_W-1:0],
                       `PAGE_OFS_W'($urandom)}, sp);
        ng = new_page(1, 1, 0, 0, 0);
        gl = new_page(1, 1, 1, 0, 0);
        miss_refill(0, va_of(ng), 0);
        miss_refill(0, va_of(gl), 0);
        asid_i = OTHER_ASID;
        miss_refill(0, va_of(ng), 0);
        expect_hit(0, va_of(gl), gl);
        asid_i = MAIN_ASID;
    endtask

    task automatic arbitration_backpressure();
        logic [`VPN_W-1:0]   lp, sp;
        logic [`VADDR_W-1:0] sva;
        test_name = "arbitration_backpressure";
        lp    = new_page(1, 1, 0, 0, 0);
        sp    = new_page(1, 1, 0, 0, 0);
        sva   = va_of(sp);
        stall = 1'b1;
        @(negedge clk);
        access(1, va_of(lp), 1, sva);
        check("ld miss", 1, ld_miss_o);
        check("st miss", 1, st_miss_o);
        @(negedge clk);
        check("ld replay", 1, ld_replay_o);
        access(0, '0, 1, sva);   // another store miss while the request waits.
        check("st miss again", 1, st_miss_o);
        @(negedge clk);
        check("st replay", 1, st_replay_o);
        repeat (4) begin
            check("held req", 1, l2_req_o);
            check("held src", SRC_STORE, l2_src_o);
            check("held vaddr", sva, l2_vaddr_o);
            @(negedge clk);
        end
        stall = 1'b0;
        wait_wb(1);
        check("wb fault", 0, wb_fault_o);
        expect_hit(1, sva, sp);
    endtask

    task automatic replacement();
        logic [`VPN_W-1:0] pages [9];
        test_name = "replacement";
        run_fence(1, '0, MAIN_ASID, 1'b1);   // start from an empty array.
        for (int i = 0; i < 9; i++) begin
            pages[i] = new_page(1, 1, 0, 0, 0);
            miss_refill(0, va_of(pages[i]), 0);
        end
        expect_hit(0, va_of(pages[1]), pages[1]);
        miss_refill(0, va_of(pages[0]), 0);
    endtask

    task automatic fences();
        logic [`VPN_W-1:0] p, q, r;
        test_name = "fences";
        run_fence(1, '0, MAIN_ASID, 1'b1);
        p = new_page(1, 1, 0, 0, 0);
        q = new_page(1, 1, 0, 0, 0);
        r = new_page(1, 1, 1, 0, 0);
        miss_refill(0, va_of(p), 0);
        miss_refill(0, va_of(q), 0);
        miss_refill(0, va_of(r), 0);
        run_fence(0, va_of(p), MAIN_ASID, 1'b0);
        expect_hit(0, va_of(q), q);
        miss_refill(0, va_of(p), 0);
        run_fence(0, va_of(r), OTHER_ASID, 1'b0);   // global always matches.
        miss_refill(0, va_of(r), 0);
        run_fence(0, va_of(q), OTHER_ASID, 1'b0);
        expect_hit(0, va_of(q), q);
        run_fence(1, '0, MAIN_ASID, 1'b0);
        miss_refill(0, va_of(p), 0);
        miss_refill(0, va_of(q), 0);
        miss_refill(0, va_of(r), 0);
    endtask

    initial begin
        void'($urandom(32'hf86baad1));
        clk              = 1'b0;
        rst              = 1'b1;
        flush_i          = 1'b0;
        asid_i           = MAIN_ASID;
        ld_req_i         = 1'b0;
        ld_vaddr_i       = '0;
        st_req_i         = 1'b0;
        st_vaddr_i       = '0;
        l2_ready_i       = 1'b1;
        l2_valid_i       = 1'b0;
        l2_src_i         = 1'b0;
        l2_error_i       = 1'b0;
        l2_vaddr_i       = '0;
        l2_ppn_i         = '0;
        l2_readable_i    = 1'b0;
        l2_writable_i    = 1'b0;
        l2_global_i      = 1'b0;
        l2_superpage_i   = 1'b0;
        fence_i          = 1'b0;
        fence_all_i      = 1'b0;
        fence_vaddr_i    = '0;
        fence_asid_i     = '0;
        fence_asid_all_i = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        reset_and_refill();
        permissions_and_faults();
        superpage_and_asid();
        arbitration_backpressure();
        replacement();
        fences();

        if (uut.u_arb.u_asrt.fail_count != 0) begin
            stop_run("a bound assertion on the miss arbiter failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
